// ==== common/zx_mem_pkg.sv ====
/*
 * Shared types and constants of the Spectrum memory and speed core
 */
`default_nettype none

package zx_mem_pkg;

	// ==============================
	// Address words
	// ==============================
	typedef logic [15:0] cpu_addr_t;  // Z80 bus address
	typedef logic [20:0] phys_addr_t; // SDRAM byte address, 2MB space

	localparam int BANK_SHIFT = 14; // 16K per slot and per bank
	localparam phys_addr_t ROM_BASE = 21'h140000;

	// ==============================
	// Paging byte
	// ==============================
	typedef struct packed {
		logic [1:0] spare;
		logic       lock;     // Freezes paging until reset
		logic       rom_sel;
		logic       screen;   // Shadow screen select
		logic [2:0] ram_bank; // Bank seen at C000
	} p128_t;

	typedef struct packed {
		logic [3:0] spare;
		logic       motor;
		logic [1:0] cfg;      // ROM high bit, or special layout
		logic       special;  // All-RAM mode
	} p3_t;

	// Same CPU byte, read as 7FFD or as 1FFD
	typedef union packed {
		p128_t p128;
		p3_t   p3;
	} page_byte_u;

	// Special mode banks, indexed by cfg then slot
	localparam logic [2:0] SPECIAL_MAP [4][4] = '{
		'{3'd0, 3'd1, 3'd2, 3'd3},
		'{3'd4, 3'd5, 3'd6, 3'd7},
		'{3'd4, 3'd5, 3'd6, 3'd3},
		'{3'd4, 3'd7, 3'd6, 3'd3}
	};

	// ==============================
	// Turbo
	// ==============================
	localparam int SPEED_W = 3;
	localparam int DIV_W   = 6;

	// Period 32 at speed 0, halved per step, speeds above 4 stay at 2
	localparam logic [DIV_W-1:0] turbo_mask [8] = '{
		6'b011111, 6'b001111, 6'b000111, 6'b000011,
		6'b000001, 6'b000001, 6'b000001, 6'b000001
	};

endpackage

`default_nettype wire

// ==== common/mem_access_if.sv ====
/*
 * One decoded CPU memory access, from the address mapper to the SDRAM port
 */
`default_nettype none

interface mem_access_if;

	logic                   start; // Request issued this cycle
	zx_mem_pkg::phys_addr_t addr;
	logic                   we;    // Write allowed, protected ROM already cleared
	logic [7:0]             din;   // CPU write data
	logic [7:0]             q;     // Read data back to the CPU
	logic                   ready; // Low while SDRAM owes an ack

	// Mapper only decides where and whether
	modport mapper (
		output addr,
		output we
	);

	modport port (
		input  addr,
		input  we,
		input  din,
		output start,
		output q,
		output ready
	);

endinterface

`default_nettype wire

// ==== hdl/paging/page_registers.sv ====
/*
 * Spectrum paging ports. 7FFD selects RAM bank and ROM,
 * 1FFD the +3 ROM pair and the all-RAM modes
 */
`default_nettype none

module page_registers #(
	parameter bit PLUS3_EN = 1'b1
) (
	input  wire logic                  clk_sys,
	input  wire logic                  reset,
	input  wire zx_mem_pkg::cpu_addr_t cpu_addr,
	input  wire logic [7:0]            cpu_dout,
	input  wire logic                  iorq,
	input  wire logic                  wr,
	output zx_mem_pkg::page_byte_u     page_7ffd,
	output zx_mem_pkg::page_byte_u     page_1ffd,
	output logic                       locked
);

	logic                   io_wr;
	logic                   io_wr_d;
	logic                   io_wr_edge;
	logic                   sel_7ffd;
	logic                   sel_1ffd;
	zx_mem_pkg::page_byte_u wr_byte;

	assign io_wr      = iorq & wr;
	assign io_wr_edge = io_wr & ~io_wr_d; // First cycle of OUT only
	assign wr_byte    = cpu_dout;

	// ==============================
	// Port decode
	// ==============================
	// On the +3 A14 keeps 7FFD apart from 1FFD
	assign sel_7ffd = ~cpu_addr[15] & ~cpu_addr[1] & (cpu_addr[14] | ~PLUS3_EN);
	assign sel_1ffd = PLUS3_EN & (cpu_addr[15:12] == 4'b0001) & ~cpu_addr[1];

	assign locked = page_7ffd.p128.lock;

	// ==============================
	// Registers
	// ==============================
	always_ff @(posedge clk_sys) begin
		if (reset) begin
			io_wr_d   <= 1'b0;
			page_7ffd <= '0;
			page_1ffd <= '0;
		end else begin
			io_wr_d <= io_wr;
			if (io_wr_edge && !locked) begin
				if (sel_7ffd) begin
					page_7ffd <= wr_byte; // Lock bit lands here too
				end else if (sel_1ffd) begin
					page_1ffd <= wr_byte;
				end
			end
		end
	end

endmodule

`default_nettype wire

// ==== hdl/paging/address_mapper.sv ====
/*
 * Maps a CPU slot address to an SDRAM address from the paging state,
 * and blocks writes into ROM
 */
`default_nettype none

module address_mapper #(
	parameter bit PLUS3_EN = 1'b1
) (
	input wire zx_mem_pkg::cpu_addr_t  cpu_addr,
	input wire logic                   wr,
	input wire zx_mem_pkg::page_byte_u page_7ffd,
	input wire zx_mem_pkg::page_byte_u page_1ffd,
	mem_access_if.mapper               acc
);

	logic                   special;
	logic                   rom_slot;
	logic [1:0]             slot;
	logic [1:0]             rom_idx;
	logic [2:0]             bank;
	zx_mem_pkg::phys_addr_t offset;

	assign slot    = cpu_addr[15:14];
	assign special = PLUS3_EN & page_1ffd.p3.special;
	assign offset  = zx_mem_pkg::phys_addr_t'(cpu_addr[zx_mem_pkg::BANK_SHIFT-1:0]);

	// +3 has four ROMs, the 128K two
	assign rom_idx = PLUS3_EN ? {page_1ffd.p3.cfg[1], page_7ffd.p128.rom_sel}
		: {1'b0, page_7ffd.p128.rom_sel};

	assign rom_slot = ~special & (slot == 2'd0);

	always_comb begin
		if (special) begin
			bank = zx_mem_pkg::SPECIAL_MAP[page_1ffd.p3.cfg][slot];
		end else begin
			case (slot)
				2'd1:    bank = 3'd5;
				2'd2:    bank = 3'd2;
				default: bank = page_7ffd.p128.ram_bank; // Slot 0 takes the ROM path
			endcase
		end
	end

	assign acc.addr = rom_slot
		? zx_mem_pkg::ROM_BASE
			+ (zx_mem_pkg::phys_addr_t'(rom_idx) << zx_mem_pkg::BANK_SHIFT) + offset
		: (zx_mem_pkg::phys_addr_t'(bank) << zx_mem_pkg::BANK_SHIFT) | offset;

	// Special modes make slot 0 writable RAM
	assign acc.we = wr & ~rom_slot;

endmodule

`default_nettype wire

// ==== hdl/speed/ce_divider.sv ====
/*
 * Free-running divider giving CPU clock-enable strobes at the turbo rate
 */
`default_nettype none

module ce_divider (
	input  wire logic                          clk_sys,
	input  wire logic                          reset,
	input  wire logic [zx_mem_pkg::SPEED_W-1:0] speed,
	output logic                               strobe
);

	logic [zx_mem_pkg::DIV_W-1:0] count;
	logic [zx_mem_pkg::DIV_W-1:0] mask;

	assign mask = zx_mem_pkg::turbo_mask[speed];

	// Low bits all zero once per period
	assign strobe = ~|(count & mask);

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			count <= '0;
		end else begin
			count <= count + 1'b1;
		end
	end

endmodule

`default_nettype wire

// ==== hdl/speed/speed_controller.sv ====
/*
 * Gates the CPU enable across turbo changes and while the SDRAM is busy
 */
`default_nettype none

module speed_controller (
	input  wire logic                          clk_sys,
	input  wire logic                          reset,
	input  wire logic [zx_mem_pkg::SPEED_W-1:0] speed_sel,
	input  wire logic                          strobe,
	input  wire logic                          ready,
	output logic [zx_mem_pkg::SPEED_W-1:0]     speed,
	output logic                               ce_cpu
);

	typedef enum logic [1:0] {
		RUN,
		SWITCH, // Counting strobes at the new rate
		SETTLE  // Waiting for the SDRAM
	} state_t;

	state_t state;
	logic   settle_cnt;
	logic   speed_change;

	assign speed_change = (speed_sel != speed);

	// Low in the same cycle speed_sel moves, and under SDRAM wait
	assign ce_cpu = strobe & ready & ~speed_change & (state == RUN);

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			state      <= SWITCH;
			speed      <= speed_sel;
			settle_cnt <= 1'b0;
		end else if (speed_change) begin
			state      <= SWITCH; // Restarts even mid-switch
			speed      <= speed_sel;
			settle_cnt <= 1'b0;
		end else begin
			case (state)
				SWITCH: begin
					if (strobe) begin
						settle_cnt <= 1'b1;
						if (settle_cnt) begin
							state <= SETTLE; // Second strobe
						end
					end
				end
				SETTLE: begin
					if (ready) begin
						state <= RUN;
					end
				end
				default: ;
			endcase
		end
	end

endmodule

`default_nettype wire

// ==== hdl/sdram_port.sv ====
/*
 * CPU side of the SDRAM. Turns an access edge into a toggle request
 * and reports ready once the ack catches up
 */
`default_nettype none

module sdram_port (
	input  wire logic             clk_sys,
	input  wire logic             reset,
	input  wire logic             mreq,
	input  wire logic             rd,
	input  wire logic             wr,
	input  wire logic             ram_ack,
	input  wire logic [7:0]       ram_q,
	mem_access_if.port            acc,
	output logic                  ram_req,
	output zx_mem_pkg::phys_addr_t ram_addr,
	output logic                  ram_we,
	output logic [7:0]            ram_din,
	output logic [7:0]            cpu_din
);

	logic       access;
	logic [2:0] access_d;  // Access over the last three edges
	logic       forbidden;
	logic       waiting;   // Request issued, data not yet taken
	logic [7:0] q_hold;

	assign access    = mreq & (rd | wr);
	assign forbidden = wr & ~acc.we; // ROM write, dropped

	// Rise seen two edges late so an OUT to a paging port has landed
	assign acc.start = access_d[1] & ~access_d[2] & ~forbidden;
	assign acc.ready = (ram_ack == ram_req);

	assign acc.q   = waiting ? ram_q : q_hold;
	assign cpu_din = acc.q;

	// ==============================
	// Handshake
	// ==============================
	always_ff @(posedge clk_sys) begin
		if (reset) begin
			access_d <= '0;
			ram_req  <= 1'b0;
			waiting  <= 1'b0;
		end else begin
			access_d <= {access_d[1:0], access};
			if (acc.start) begin
				ram_req <= ~ram_req;
				waiting <= 1'b1;
			end else if (acc.ready) begin
				waiting <= 1'b0;
			end
		end
	end

	// Held stable until the next request
	always_ff @(posedge clk_sys) begin
		if (acc.start) begin
			ram_addr <= acc.addr;
			ram_we   <= acc.we;
			ram_din  <= acc.din;
		end
		if (waiting && acc.ready) begin
			q_hold <= ram_q;
		end
	end

endmodule

`default_nettype wire

// ==== hdl/spectrum_memory_core.sv ====
/*
 * Spectrum memory and speed core between the Z80 bus and a byte-wide SDRAM
 */
`default_nettype none

module spectrum_memory_core #(
	parameter bit PLUS3_EN = 1'b1
) (
	input  wire logic                           clk_sys,
	input  wire logic                           reset,
	input  wire zx_mem_pkg::cpu_addr_t          cpu_addr,
	input  wire logic [7:0]                     cpu_dout,
	input  wire logic                           mreq,
	input  wire logic                           iorq,
	input  wire logic                           rd,
	input  wire logic                           wr,
	input  wire logic [zx_mem_pkg::SPEED_W-1:0] speed_sel,
	input  wire logic                           ram_ack,
	input  wire logic [7:0]                     ram_q,
	output logic                                ce_cpu,
	output logic [7:0]                          cpu_din,
	output logic                                ram_req,
	output zx_mem_pkg::phys_addr_t              ram_addr,
	output logic                                ram_we,
	output logic [7:0]                          ram_din
);

	zx_mem_pkg::page_byte_u           page_7ffd;
	zx_mem_pkg::page_byte_u           page_1ffd;
	logic [zx_mem_pkg::SPEED_W-1:0]   speed;
	logic                             strobe;

	mem_access_if acc ();

	assign acc.din = cpu_dout;

	// ==============================
	// Paging
	// ==============================
	page_registers #(.PLUS3_EN(PLUS3_EN)) u_page_registers (
		.clk_sys   (clk_sys),
		.reset     (reset),
		.cpu_addr  (cpu_addr),
		.cpu_dout  (cpu_dout),
		.iorq      (iorq),
		.wr        (wr),
		.page_7ffd (page_7ffd),
		.page_1ffd (page_1ffd),
		.locked    ()              // Lock is already bit 5 of page_7ffd
	);

	address_mapper #(.PLUS3_EN(PLUS3_EN)) u_address_mapper (
		.cpu_addr  (cpu_addr),
		.wr        (wr),
		.page_7ffd (page_7ffd),
		.page_1ffd (page_1ffd),
		.acc       (acc.mapper)
	);

	// ==============================
	// SDRAM
	// ==============================
	sdram_port u_sdram_port (
		.clk_sys  (clk_sys),
		.reset    (reset),
		.mreq     (mreq),
		.rd       (rd),
		.wr       (wr),
		.ram_ack  (ram_ack),
		.ram_q    (ram_q),
		.acc      (acc.port),
		.ram_req  (ram_req),
		.ram_addr (ram_addr),
		.ram_we   (ram_we),
		.ram_din  (ram_din),
		.cpu_din  (cpu_din)
	);

	// ==============================
	// Speed
	// ==============================
	ce_divider u_ce_divider (
		.clk_sys (clk_sys),
		.reset   (reset),
		.speed   (speed),
		.strobe  (strobe)
	);

	speed_controller u_speed_controller (
		.clk_sys   (clk_sys),
		.reset     (reset),
		.speed_sel (speed_sel),
		.strobe    (strobe),
		.ready     (acc.ready),
		.speed     (speed),
		.ce_cpu    (ce_cpu)
	);

endmodule

`default_nettype wire

// ==== testbench/memory_checker.sv ====
/*
 * Assertions on the SDRAM toggle handshake and its reset state
 */
`default_nettype none

module memory_checker (
	input wire logic                   clk_sys,
	input wire logic                   reset,
	input wire logic                   ram_req,
	input wire logic                   ram_ack,
	input wire zx_mem_pkg::phys_addr_t ram_addr,
	input wire logic                   ram_we,
	input wire logic [7:0]             ram_din
);
	timeunit 1ns;
	timeprecision 100ps;

	logic outstanding;

	assign outstanding = (ram_req != ram_ack); // Ready low

	a_addr_stable: assert property (@(posedge clk_sys) disable iff (reset)
		outstanding && $past(outstanding) |-> $stable(ram_addr) && $stable(ram_we)
			&& $stable(ram_din))
		else $error("SDRAM address or data moved while a request was outstanding");

	a_single_request: assert property (@(posedge clk_sys) disable iff (reset)
		outstanding |=> $stable(ram_req))
		else $error("ram_req toggled while a request was outstanding");

	a_reset_state: assert property (@(posedge clk_sys) reset |=> !ram_req)
		else $error("ram_req not cleared by reset");

endmodule

bind sdram_port memory_checker u_memory_checker (
	.clk_sys  (clk_sys),
	.reset    (reset),
	.ram_req  (ram_req),
	.ram_ack  (ram_ack),
	.ram_addr (ram_addr),
	.ram_we   (ram_we),
	.ram_din  (ram_din)
);

`default_nettype wire

// ==== testbench/tb_spectrum_memory.sv ====
/*
 * Testbench of the Spectrum memory core. Random Z80 bus traffic, an SDRAM
 * responder and a reference model of paging, mapping and turbo timing
 */
`default_nettype none

module tb_spectrum_memory;
	timeunit 1ns;
	timeprecision 100ps;

	localparam int          CLK_PERIOD    = 20;
	localparam int          N_ACCESS      = 240;  // Upper bound over all tests
	localparam int          ACCESS_CYCLES = 24;   // Bus, latency, ack and io writes
	localparam int          SPEED_CYCLES  = 5 * 12 * 32;
	localparam int          WATCHDOG_CYCLES = N_ACCESS * ACCESS_CYCLES + SPEED_CYCLES + 200;
	localparam logic [20:0] ROM_BASE      = 21'h140000;

	logic clk_sys, reset, mreq, iorq, rd, wr, ram_ack, ce_cpu, ram_req, ram_we;
	logic [15:0] cpu_addr;
	logic [7:0]  cpu_dout, ram_q, cpu_din, ram_din;
	logic [2:0]  speed_sel;
	logic [20:0] ram_addr;

	logic [7:0]  m_7ffd, m_1ffd;          // Model paging registers
	logic [7:0]  ref_mem [logic [20:0]];  // Expected memory contents
	logic [7:0]  sdram_mem [logic [20:0]];
	integer      seed = 5627;
	int          checks = 0;
	int          errors = 0;

	spectrum_memory_core #(.PLUS3_EN(1'b1)) u_dut (
		.clk_sys (clk_sys), .reset (reset), .cpu_addr (cpu_addr), .cpu_dout (cpu_dout),
		.mreq (mreq), .iorq (iorq), .rd (rd), .wr (wr), .speed_sel (speed_sel),
		.ram_ack (ram_ack), .ram_q (ram_q), .ce_cpu (ce_cpu), .cpu_din (cpu_din),
		.ram_req (ram_req), .ram_addr (ram_addr), .ram_we (ram_we), .ram_din (ram_din)
	);

	always #(CLK_PERIOD / 2) clk_sys = ~clk_sys;

	// ==============================
	// Reference model
	// ==============================
	function automatic logic [7:0] fill_byte(input logic [20:0] a);
		return a[7:0] ^ a[15:8] ^ {3'b000, a[20:16]};
	endfunction

	function automatic logic [20:0] model_addr(input logic [15:0] a);
		logic [1:0] slot;
		logic [2:0] bank;
		slot = a[15:14];
		if (m_1ffd[0]) begin
			case (m_1ffd[2:1])
				2'd0:    bank = {1'b0, slot};
				2'd1:    bank = {1'b1, slot};
				2'd2:    bank = (slot == 2'd3) ? 3'd3 : {1'b1, slot};
				default: bank = (slot == 2'd0) ? 3'd4 : (slot == 2'd1) ? 3'd7
					: (slot == 2'd2) ? 3'd6 : 3'd3;
			endcase
			return {4'd0, bank, a[13:0]};
		end
		case (slot)
			2'd0:    return ROM_BASE + {5'd0, m_1ffd[2], m_7ffd[4], a[13:0]};
			2'd1:    return {4'd0, 3'd5, a[13:0]};
			2'd2:    return {4'd0, 3'd2, a[13:0]};
			default: return {4'd0, m_7ffd[2:0], a[13:0]};
		endcase
	endfunction

	function automatic logic model_writable(input logic [15:0] a);
		return m_1ffd[0] || (a[15:14] != 2'd0); // ROM only in normal mode
	endfunction

	// ==============================
	// Bus tasks
	// ==============================
	task automatic next_drive();
		@(posedge clk_sys);
		#2;
	endtask

	task automatic compare(input string name, input logic [31:0] got, input logic [31:0] exp);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("CHECK FAILED %s: got 0x%h, expected 0x%h", name, got, exp);
		end
	endtask

	task automatic apply_reset();
		next_drive();
		reset = 1'b1;
		ram_ack = 1'b0;
		repeat (4) @(posedge clk_sys);
		#2;
		reset = 1'b0;
		m_7ffd = 8'h00;
		m_1ffd = 8'h00;
	endtask

	task automatic io_write(input logic [15:0] port, input logic [7:0] data);
		next_drive();
		cpu_addr = port;
		cpu_dout = data;
		iorq = 1'b1;
		wr = 1'b1;
		next_drive();
		iorq = 1'b0;
		wr = 1'b0;
		if (!m_7ffd[5]) begin // Lock freezes both ports
			if (port == 16'h7FFD) begin
				m_7ffd = data;
			end else if (port == 16'h1FFD) begin
				m_1ffd = data;
			end
		end
	endtask

	task automatic mem_access(input logic [15:0] a, input logic write, input logic [7:0] data);
		logic [20:0] exp_addr;
		logic [7:0]  exp_q;
		logic        allowed;
		logic        req_before;
		int          n;
		exp_addr = model_addr(a);
		allowed = !write || model_writable(a);
		exp_q = ref_mem.exists(exp_addr) ? ref_mem[exp_addr] : fill_byte(exp_addr);
		req_before = ram_req;
		next_drive();
		cpu_addr = a;
		cpu_dout = data;
		mreq = 1'b1;
		rd = !write;
		wr = write;
		n = 0;
		while (ram_req == req_before && n < 6) begin
			@(negedge clk_sys);
			n++;
		end
		if (!allowed) begin
			compare("ram_req", 32'(ram_req), 32'(req_before)); // ROM write dropped
		end else if (ram_req == req_before) begin
			checks++;
			errors++;
			$display("No SDRAM request for the access at 0x%h", a);
		end else begin
			checks++;
			if (n != 4) begin // Sampled one edge on, toggled two edges after that
				errors++;
				$display("SDRAM request came %0d cycles after the access, not 4", n);
			end
			compare("ram_addr", 32'(ram_addr), 32'(exp_addr));
			compare("ram_we", 32'(ram_we), 32'(write));
			if (write) begin
				compare("ram_din", 32'(ram_din), 32'(data));
			end
			n = 0;
			while (ram_ack != ram_req && n < 20) begin
				@(negedge clk_sys);
				n++;
			end
			@(negedge clk_sys);
			if (write) begin
				ref_mem[exp_addr] = data;
			end else begin
				compare("cpu_din", 32'(cpu_din), 32'(exp_q));
			end
		end
		next_drive();
		mreq = 1'b0;
		rd = 1'b0;
		wr = 1'b0;
	endtask

	task automatic speed_check(input logic [2:0] s);
		int period;
		int gap;
		int spacing;
		period = 32 >> s;
		next_drive();
		speed_sel = s;
		gap = 0;
		do begin
			@(negedge clk_sys);
			gap++;
		end while (!ce_cpu && gap < 12 * 32);
		checks++;
		if (!ce_cpu || gap < 2 * period) begin
			errors++;
			$display("CPU enable after switch to speed %0d came after %0d cycles", s, gap);
		end
		repeat (4) begin
			spacing = 0;
			do begin
				@(negedge clk_sys);
				spacing++;
			end while (!ce_cpu && spacing < 64);
			compare("ce_cpu spacing", 32'(spacing), 32'(period));
		end
	endtask

	task automatic report_test(input int num, input string name, input int base);
		$display("test %0d %s: %0d errors", num, name, errors - base);
	endtask

	// SDRAM model, acks 1 to 6 cycles after a toggle
	initial begin : sdram_responder
		logic [31:0] r;
		int          delay;
		forever begin
			@(negedge clk_sys);
			if (!reset && ram_req != ram_ack) begin
				r = $random(seed);
				delay = 1 + int'(r[7:0]) % 6;
				repeat (delay) @(posedge clk_sys);
				#2;
				if (ram_we) begin
					sdram_mem[ram_addr] = ram_din;
				end else begin
					ram_q = sdram_mem.exists(ram_addr) ? sdram_mem[ram_addr] : fill_byte(ram_addr);
				end
				ram_ack = ram_req;
			end
		end
	end

	initial begin : watchdog
		repeat (WATCHDOG_CYCLES) @(posedge clk_sys);
		$display("Timeout: run still going after %0d cycles", WATCHDOG_CYCLES);
		$display("Test FAILED");
		$finish;
	end

	// ==============================
	// Test sequence
	// ==============================
	initial begin : main
		logic [31:0] r;
		int          base;
		clk_sys = 1'b0;
		reset = 1'b1;
		{mreq, iorq, rd, wr, ram_ack} = 5'b0;
		cpu_addr = 16'h0000;
		cpu_dout = 8'h00;
		speed_sel = 3'd0;
		ram_q = 8'h00;
		apply_reset();

		base = errors;
		for (int slot = 0; slot < 4; slot++) begin
			r = $random(seed);
			mem_access({slot[1:0], r[13:0]}, 1'b0, 8'h00);
		end
		report_test(1, "reset mapping", base);

		base = errors;
		repeat (30) begin
			r = $random(seed);
			io_write(16'h7FFD, r[7:0] & 8'hDF); // Lock stays clear
			repeat (4) begin
				r = $random(seed);
				mem_access(r[15:0], r[16], r[31:24]);
			end
		end
		report_test(2, "random paging", base);

		base = errors;
		r = $random(seed);
		io_write(16'h7FFD, r[7:0] | 8'h20);
		repeat (10) begin
			r = $random(seed);
			io_write(r[0] ? 16'h7FFD : 16'h1FFD, r[15:8]);
			mem_access({r[31:30], r[29:16]}, r[1], r[23:16]);
		end
		apply_reset();
		report_test(3, "paging lock", base);

		base = errors;
		for (int cfg = 0; cfg < 4; cfg++) begin
			r = $random(seed);
			io_write(16'h1FFD, {r[7:3], cfg[1:0], 1'b1});
			for (int slot = 0; slot < 4; slot++) begin
				r = $random(seed);
				mem_access({slot[1:0], r[13:0]}, 1'b1, r[31:24]);
				mem_access({slot[1:0], r[13:0]}, 1'b0, 8'h00); // Read back
			end
		end
		apply_reset();
		report_test(4, "special modes", base);

		base = errors;
		for (int i = 1; i <= 5; i++) begin
			speed_check(3'(i % 5));
		end
		report_test(5, "turbo speeds", base);

		$display("checks %0d, errors %0d", checks, errors);
		if (errors == 0) begin
			$display("Test OK");
		end else begin
			$display("Test FAILED");
		end
		$finish;
	end

endmodule

`default_nettype wire

// ==== list.f ====
common/zx_mem_pkg.sv
common/mem_access_if.sv
hdl/paging/page_registers.sv
hdl/paging/address_mapper.sv
hdl/speed/ce_divider.sv
hdl/speed/speed_controller.sv
hdl/sdram_port.sv
hdl/spectrum_memory_core.sv
testbench/memory_checker.sv
testbench/tb_spectrum_memory.sv

// ==== Makefile ====
VERILATOR = verilator
VFLAGS    = --binary --timing --assert -j 0
TOP       = tb_spectrum_memory
FILELIST  = list.f
OBJ_DIR   = obj_dir
LOG       = sim.log

BIN     = $(OBJ_DIR)/V$(TOP)
SOURCES = $(shell grep -v '^+' $(FILELIST))

.PHONY: all run clean

all: run

$(BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(BIN)
	./$(BIN) > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	if [ $$status -ne 0 ] || grep -q "Test FAILED" $(LOG); then exit 1; fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)
